// File: sdEngine.f
logic/sdEnginePkg.sv
logic/sdCmdFetch.sv
logic/sdCardSequencer.sv
logic/sdResultQueue.sv
logic/sdEngine.sv
tests/sdCardModel.sv
tests/sdEngineTb.sv

// File: Makefile
SIM := obj_dir/VsdEngineTb
SRCS := $(wildcard logic/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): sdEngine.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module sdEngineTb -f sdEngine.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/sdEngineTb.sv
// testbench for the SD card command engine
//    clock, reset, command and result FIFO models
//    bring-up order, transfers, result back-pressure, opcode filter

`timescale 1ns/100ps

module sdEngineTb import sdEnginePkg::*; ();

   localparam rcaT      modelRca    = 16'h5A3C;
   localparam dataStatT modelStatus = 4'hA;
   localparam int       waitLimit   = 2000;
   localparam int evCmd    = 0;
   localparam int evResp   = 1;
   localparam int evResult = 2;
   localparam int evRdEn   = 3;
   localparam int evReady  = 4;

   logic       sdClkIn;
   logic       initRst;
   cmdWordT    cmdFifoData;
   logic       cmdFifoEmpty;
   logic       cmdFifoRdEn;
   logic       initDone;
   logic       dataReady;
   shortRespT  cmdResponse;
   sdCmdReqT   sdCmd;
   logic       writeDone;
   logic       readDone;
   dataStatT   dataStatus;
   logic       writeFifoAlmostEmpty;
   logic       readFifoAlmostFull;
   logic       writeCmd;
   logic       readCmd;
   logic       resultFifoFull;
   logic       resultFifoWrEn;
   resultWordT resultFifoData;
   logic       sdReady;

   cmdWordT    cmdQ[$];
   resultWordT resultQ[$];
   cmdWordT    pushWord;
   logic       pushValid;
   logic [7:0] cmdIdx[$];     // one entry per newCmd
   sdArgT      cmdArg[$];
   int         cmdCycle[$];
   int         seen[5];       // event counters, indexed by ev*
   int         cycle;
   int         writePulses;
   int         readPulses;
   int         strobeCycle;
   int         respCycle;     // last command response
   int         doneCycle;     // last data path completion

   sdEngine uut (.*);

   sdCardModel #(.cardRca(modelRca), .xferStatus(modelStatus)) card (
      .sdClkIn, .initRst, .sdCmd, .writeCmd, .readCmd,
      .dataReady, .cmdResponse, .writeDone, .readDone, .dataStatus
   );

   initial begin
      sdClkIn = 1'b0;
      forever #5 sdClkIn = !sdClkIn;
   end

   ////////////////////////////////////////////////////////////
   // error reporting and waits
   ////////////////////////////////////////////////////////////
   task automatic reportMismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
      $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic reportFailure(input string what);
      $display("Error at time %0t: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic expectEqual(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual == expected) else reportMismatch(name, expected, actual);
   endtask

   task automatic awaitCount(input int which, input int target, input string what);
      int waited;
      waited = 0;
      while (seen[which] < target) begin
         @(negedge sdClkIn);
         waited++;
         if (waited > waitLimit) reportFailure({"timeout waiting for ", what});
      end
   endtask

   ////////////////////////////////////////////////////////////
   // FIFO models and monitor
   ////////////////////////////////////////////////////////////
   always @(posedge sdClkIn) begin
      cycle <= cycle + 1;
      if (pushValid) cmdQ.push_back(pushWord);
      if (cmdFifoRdEn) begin
         seen[evRdEn]++;
         if (cmdQ.size() > 0) cmdFifoData <= cmdQ.pop_front();   // valid next cycle
      end
      cmdFifoEmpty <= (cmdQ.size() == 0);
      if (resultFifoWrEn) begin
         resultQ.push_back(resultFifoData);
         seen[evResult]++;
      end
      if (sdCmd.newCmd) begin
         cmdIdx.push_back(sdCmd.setting[15:8]);
         cmdArg.push_back(sdCmd.argument);
         cmdCycle.push_back(cycle);
         seen[evCmd]++;
         if (seen[evCmd] <= 14) assert (!sdReady) else reportFailure("sdReady high in bring-up");
      end
      if (dataReady) begin
         seen[evResp]++;
         respCycle = cycle;
      end
      if (sdReady) seen[evReady] = 1;
      if (writeCmd) writePulses++;
      if (readCmd) readPulses++;
      if (writeCmd || readCmd) strobeCycle = cycle;
      if (writeDone || readDone) doneCycle = cycle;
   end

   rdEnOnEmpty: assert property (@(posedge sdClkIn) disable iff (initRst)
      !(cmdFifoRdEn && cmdFifoEmpty)) else reportFailure("cmdFifoRdEn while cmdFifoEmpty high");
   wrEnOnFull: assert property (@(posedge sdClkIn) disable iff (initRst)
      !(resultFifoWrEn && resultFifoFull)) else reportFailure("resultFifoWrEn while FIFO full");
   readyHolds: assert property (@(posedge sdClkIn) disable iff (initRst)
      sdReady |=> sdReady) else reportFailure("sdReady fell after bring-up");
   // flag as the sequencer saw it two edges before the strobe
   writeHeldOff: assert property (@(posedge sdClkIn) disable iff (initRst)
      sdCmd.newCmd && sdCmd.setting[15:8] == 8'd24 |-> !$past(writeFifoAlmostEmpty, 2))
      else reportFailure("CMD24 issued while writeFifoAlmostEmpty high");
   readHeldOff: assert property (@(posedge sdClkIn) disable iff (initRst)
      sdCmd.newCmd && sdCmd.setting[15:8] == 8'd17 |-> !$past(readFifoAlmostFull, 2))
      else reportFailure("CMD17 issued while readFifoAlmostFull high");

   ////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////
   function automatic cmdWordT makeCmdWord(input opcodeT op, input tagT tag, input sdArgT addr);
      return {8'h00, op, tag, 18'h0, addr};
   endfunction

   function automatic resultWordT expectedResult(input tagT tag, input logic [5:0] index);
      return {17'b0, modelStatus, 1'b0, index, tag};
   endfunction

   task automatic pushCommand(input cmdWordT word);
      @(posedge sdClkIn);
      pushWord  <= word;
      pushValid <= 1'b1;
      @(posedge sdClkIn);
      pushValid <= 1'b0;
   endtask

   task automatic runTransfer(input logic isWrite, input tagT tag, input sdArgT addr,
                              input logic holdFlag);
      int firstCmd;
      int firstResult;
      logic [5:0] index;
      index = isWrite ? 6'd24 : 6'd17;
      firstCmd = seen[evCmd];
      firstResult = seen[evResult];
      writePulses = 0;
      readPulses = 0;
      @(posedge sdClkIn);
      if (isWrite) writeFifoAlmostEmpty <= holdFlag;
      else readFifoAlmostFull <= holdFlag;
      pushCommand(makeCmdWord(isWrite ? opWrite : opRead, tag, addr));
      if (holdFlag) begin
         repeat (40) @(negedge sdClkIn);
         expectEqual("newCmd count with data flag held", firstCmd, seen[evCmd]);
         @(posedge sdClkIn);
         writeFifoAlmostEmpty <= 1'b0;
         readFifoAlmostFull   <= 1'b0;
      end
      awaitCount(evCmd, firstCmd + 1, "transfer command");
      expectEqual("sdCmd.setting index", index, cmdIdx[firstCmd]);
      expectEqual("sdCmd.argument", addr, cmdArg[firstCmd]);
      awaitCount(evResult, firstResult + 1, "transfer result");
      expectEqual("resultFifoData", expectedResult(tag, index), resultQ.pop_front());
      expectEqual("writeCmd pulses", isWrite, writePulses);
      expectEqual("readCmd pulses", !isWrite, readPulses);
      assert (strobeCycle > respCycle && strobeCycle < doneCycle)
         else reportFailure("data strobe not between command response and completion");
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      logic [7:0] expIdx[14];
      sdArgT      expArg[14];
      int         firstCmd;
      int         firstResult;
      int         firstRead;
      initRst = 1'b1;
      initDone = 1'b0;
      cmdFifoData = '0;
      cmdFifoEmpty = 1'b1;
      pushWord = '0;
      pushValid = 1'b0;
      writeFifoAlmostEmpty = 1'b0;
      readFifoAlmostFull = 1'b0;
      resultFifoFull = 1'b0;
      cycle = 0;
      writePulses = 0;
      readPulses = 0;
      strobeCycle = 0;
      respCycle = 0;
      doneCycle = 0;
      seen = '{default: 0};
      expIdx = '{8'd0, 8'd8, 8'd55, 8'd41, 8'd55, 8'd41, 8'd55, 8'd41,
                 8'd2, 8'd3, 8'd7, 8'd55, 8'd6, 8'd16};
      expArg = '{32'h0, cmd8Arg, {16'h0, cmd55StuffBits}, acmd41Arg,
                 {16'h0, cmd55StuffBits}, acmd41Arg, {16'h0, cmd55StuffBits}, acmd41Arg,
                 32'h0, 32'h0, {modelRca, 16'h0}, {modelRca, cmd55StuffBits},
                 acmd6Arg, blockLenArg};
      repeat (2) @(posedge sdClkIn);
      initRst <= 1'b0;

      repeat (4) begin   // idle while the PHY is down
         @(negedge sdClkIn);
         expectEqual("newCmd/writeCmd/readCmd/cmdFifoRdEn/resultFifoWrEn/sdReady", 0,
                     {sdCmd.newCmd, writeCmd, readCmd, cmdFifoRdEn, resultFifoWrEn, sdReady});
      end
      @(posedge sdClkIn);
      initDone <= 1'b1;
      awaitCount(evReady, 1, "sdReady");
      expectEqual("newCmd count at sdReady", 14, seen[evCmd]);
      expectEqual("dataReady count at sdReady", 13, seen[evResp]);
      for (int i = 0; i < 14; i++) begin
         expectEqual($sformatf("index of command %0d", i), expIdx[i], cmdIdx[i]);
         expectEqual($sformatf("argument of command %0d", i), expArg[i], cmdArg[i]);
      end
      assert (cmdCycle[1] - cmdCycle[0] > cmd0WaitCycles)
         else reportFailure("CMD8 issued inside the CMD0 wait");

      runTransfer(1'b1, 8'h31, 32'h0000_1200, 1'b0);
      runTransfer(1'b1, 8'h32, 32'h0000_2400, 1'b1);
      runTransfer(1'b0, 8'h41, 32'h0001_0000, 1'b0);
      runTransfer(1'b0, 8'h42, 32'h00AB_CDEF, 1'b1);

      // three transfers against a full result FIFO
      firstCmd = seen[evCmd];
      firstResult = seen[evResult];
      @(posedge sdClkIn);
      resultFifoFull <= 1'b1;
      pushCommand(makeCmdWord(opWrite, 8'h51, 32'h0000_0100));
      pushCommand(makeCmdWord(opRead, 8'h52, 32'h0000_0200));
      pushCommand(makeCmdWord(opWrite, 8'h53, 32'h0000_0300));
      awaitCount(evCmd, firstCmd + 2, "second stalled transfer");
      repeat (40) @(negedge sdClkIn);
      expectEqual("results while FIFO full", firstResult, seen[evResult]);
      expectEqual("newCmd count while stalled", firstCmd + 2, seen[evCmd]);
      @(posedge sdClkIn);
      resultFifoFull <= 1'b0;
      awaitCount(evResult, firstResult + 3, "results after release");
      expectEqual("resultFifoData", expectedResult(8'h51, 6'd24), resultQ.pop_front());
      expectEqual("resultFifoData", expectedResult(8'h52, 6'd17), resultQ.pop_front());
      expectEqual("resultFifoData", expectedResult(8'h53, 6'd24), resultQ.pop_front());

      // opcode 9 is fetched and dropped
      firstCmd = seen[evCmd];
      firstResult = seen[evResult];
      firstRead = seen[evRdEn];
      pushCommand(makeCmdWord(6'd9, 8'h61, 32'h0000_0400));
      awaitCount(evRdEn, firstRead + 1, "fetch of opcode 9");
      repeat (30) @(negedge sdClkIn);
      expectEqual("newCmd count after opcode 9", firstCmd, seen[evCmd]);
      expectEqual("result count after opcode 9", firstResult, seen[evResult]);
      runTransfer(1'b1, 8'h62, 32'h0000_0500, 1'b0);

      repeat (5) @(negedge sdClkIn);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: tests/sdCardModel.sv
// behavioral command PHY, card and data path
//    command responses after a pseudo-random delay of 1 to 8 cycles
//    ACMD41 busy for two attempts, fixed RCA in the CMD3 response
//    write and read completion with a fixed status

`timescale 1ns/100ps

module sdCardModel import sdEnginePkg::*; #(
   parameter rcaT      cardRca    = 16'h5A3C,
   parameter dataStatT xferStatus = 4'hA
) (
   input  logic      sdClkIn,
   input  logic      initRst,
   input  sdCmdReqT  sdCmd,
   input  logic      writeCmd,
   input  logic      readCmd,
   output logic      dataReady,
   output shortRespT cmdResponse,
   output logic      writeDone,
   output logic      readDone,
   output dataStatT  dataStatus
);

   logic [7:0] lfsr;
   logic [7:0] lfsrNext;
   logic [3:0] nextDelay;
   logic [3:0] cmdDelay;      // 0 when nothing pending
   logic [3:0] dataDelay;
   logic [5:0] cmdIndex;
   logic       dataWrite;
   logic [1:0] acmd41Tries;

   function automatic logic [7:0] lfsrStep(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};   // taps 8 6 5 4
   endfunction

   // three steps, one for each delay bit
   function automatic logic [7:0] drawDelay(input logic [7:0] s);
      logic [7:0] t;
      t = lfsrStep(s);
      t = lfsrStep(t);
      t = lfsrStep(t);
      return t;
   endfunction

   function automatic shortRespT responseFor(input logic [5:0] index, input logic [1:0] tries);
      shortRespT r;
      r = '0;
      r[45:40] = index;
      if (index == 6'd41) r[ocrReadyBit] = (tries >= 2'd2);   // busy twice
      if (index == 6'd3)  r[39:24] = cardRca;
      return r;
   endfunction

   assign lfsrNext   = drawDelay(lfsr);
   assign nextDelay  = {1'b0, lfsrNext[2:0]} + 4'd1;
   assign dataStatus = xferStatus;

   always @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         lfsr        <= 8'd87;
         cmdDelay    <= '0;
         dataDelay   <= '0;
         cmdIndex    <= '0;
         dataWrite   <= 1'b0;
         acmd41Tries <= '0;
         dataReady   <= 1'b0;
         cmdResponse <= '0;
         writeDone   <= 1'b0;
         readDone    <= 1'b0;
      end else begin
         dataReady <= 1'b0;
         writeDone <= 1'b0;
         readDone  <= 1'b0;
         if (sdCmd.newCmd && sdCmd.setting[15:8] != 8'd0) begin   // CMD0 is never answered
            lfsr     <= lfsrNext;
            cmdDelay <= nextDelay;
            cmdIndex <= sdCmd.setting[13:8];
         end else if (cmdDelay == 4'd1) begin
            dataReady   <= 1'b1;
            cmdResponse <= responseFor(cmdIndex, acmd41Tries);
            cmdDelay    <= '0;
            if (cmdIndex == 6'd41 && acmd41Tries != 2'd3) acmd41Tries <= acmd41Tries + 2'd1;
         end else if (cmdDelay != 4'd0) begin
            cmdDelay <= cmdDelay - 4'd1;
         end
         // data path completion
         if (writeCmd || readCmd) begin
            lfsr      <= lfsrNext;
            dataDelay <= nextDelay;
            dataWrite <= writeCmd;
         end else if (dataDelay == 4'd1) begin
            writeDone <= dataWrite;
            readDone  <= !dataWrite;
            dataDelay <= '0;
         end else if (dataDelay != 4'd0) begin
            dataDelay <= dataDelay - 4'd1;
         end
      end
   end

endmodule

// File: logic/sdEngine.sv
// SD card command engine top level
//    decode, execute and result stages
//    card command PHY, data path and FIFO connections

`timescale 1ns/100ps

module sdEngine import sdEnginePkg::*; (
   input  logic       sdClkIn,
   input  logic       initRst,
   // command FIFO
   input  cmdWordT    cmdFifoData,
   input  logic       cmdFifoEmpty,
   output logic       cmdFifoRdEn,
   // command PHY
   input  logic       initDone,
   input  logic       dataReady,
   input  shortRespT  cmdResponse,
   output sdCmdReqT   sdCmd,
   // data path
   input  logic       writeDone,
   input  logic       readDone,
   input  dataStatT   dataStatus,
   input  logic       writeFifoAlmostEmpty,
   input  logic       readFifoAlmostFull,
   output logic       writeCmd,
   output logic       readCmd,
   // result FIFO
   input  logic       resultFifoFull,
   output logic       resultFifoWrEn,
   output resultWordT resultFifoData,
   output logic       sdReady
);

   xferReqT  xferReq;
   logic     reqValid;
   logic     reqTaken;
   xferDoneT xferDone;
   logic     doneValid;
   logic     resultSpace;

   sdCmdFetch fetch (
      .sdClkIn, .initRst, .sdReady,
      .cmdFifoData, .cmdFifoEmpty, .reqTaken,
      .cmdFifoRdEn, .xferReq, .reqValid
   );

   sdCardSequencer sequencer (
      .sdClkIn, .initRst, .initDone, .dataReady, .cmdResponse,
      .xferReq, .reqValid,
      .writeFifoAlmostEmpty, .readFifoAlmostFull,
      .writeDone, .readDone, .dataStatus, .resultSpace,
      .sdCmd, .sdReady, .reqTaken, .writeCmd, .readCmd,
      .xferDone, .doneValid
   );

   sdResultQueue results (
      .sdClkIn, .initRst,
      .xferDone, .doneValid, .resultFifoFull,
      .resultSpace, .resultFifoWrEn, .resultFifoData
   );

endmodule

// File: logic/sdResultQueue.sv
// result stage of the SD engine
//    one entry result register
//    result word packing and result FIFO write

`timescale 1ns/100ps

module sdResultQueue import sdEnginePkg::*; (
   input  logic       sdClkIn,
   input  logic       initRst,
   input  xferDoneT   xferDone,
   input  logic       doneValid,
   input  logic       resultFifoFull,
   output logic       resultSpace,
   output logic       resultFifoWrEn,
   output resultWordT resultFifoData
);

   logic resultPending;   // word waiting for FIFO room
   logic handOff;

   assign resultSpace    = !resultPending;
   assign handOff        = doneValid && resultSpace;
   assign resultFifoWrEn = resultPending && !resultFifoFull;

   ////////////////////////////////////////////////////////////
   // occupancy
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         resultPending <= 1'b0;
      end else if (handOff) begin
         resultPending <= 1'b1;
      end else if (resultFifoWrEn) begin
         resultPending <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // result word
   ////////////////////////////////////////////////////////////
   // upper 17 bits and bit 14 stay zero
   always_ff @(posedge sdClkIn) begin
      if (handOff) begin
         resultFifoData <= {17'b0,
                            xferDone.dataStatus,
                            1'b0,
                            xferDone.respIndex,
                            xferDone.tag};
      end
   end

   // full flag from the FIFO side must block the write
   wrEnNotFull: assert property (@(posedge sdClkIn) disable iff (initRst)
      resultFifoWrEn |-> !resultFifoFull)
      else $error("result FIFO written while full");

endmodule

// File: logic/sdCardSequencer.sv
// execute stage of the SD engine
//    card bring-up FSM, CMD0 through CMD16
//    RCA capture and ACMD41 / ACMD6 progress flags
//    single block write and read sequencing
//    completion hand-off to the result stage

`timescale 1ns/100ps

module sdCardSequencer import sdEnginePkg::*; (
   input  logic      sdClkIn,
   input  logic      initRst,
   input  logic      initDone,
   input  logic      dataReady,
   input  shortRespT cmdResponse,
   input  xferReqT   xferReq,
   input  logic      reqValid,
   input  logic      writeFifoAlmostEmpty,
   input  logic      readFifoAlmostFull,
   input  logic      writeDone,
   input  logic      readDone,
   input  dataStatT  dataStatus,
   input  logic      resultSpace,
   output sdCmdReqT  sdCmd,
   output logic      sdReady,
   output logic      reqTaken,
   output logic      writeCmd,
   output logic      readCmd,
   output xferDoneT  xferDone,
   output logic      doneValid
);

   seqStateT state;
   logic [$clog2(cmd0WaitCycles):0] cmdWaitCnt;
   logic acmd41Done;   // card left busy
   logic acmd6Done;    // wide bus set
   rcaT  rca;
   xferReqT curReq;

   // command strobe with argument and setting
   function automatic sdCmdReqT issue(input sdArgT arg, input logic [7:0] index,
                                      input logic [7:0] flags);
      return '{newCmd: 1'b1, argument: arg, setting: {index, flags}};
   endfunction

   assign reqTaken = (state == sReady) && reqValid;

   ////////////////////////////////////////////////////////////
   // main FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         state      <= sIdle;
         sdCmd      <= '0;
         sdReady    <= 1'b0;
         writeCmd   <= 1'b0;
         readCmd    <= 1'b0;
         doneValid  <= 1'b0;
         cmdWaitCnt <= '0;
         acmd41Done <= 1'b0;
         acmd6Done  <= 1'b0;
         rca        <= '0;
         curReq     <= '0;
         xferDone   <= '0;
      end else begin
         sdCmd.newCmd <= 1'b0;   // strobes last one cycle
         writeCmd     <= 1'b0;
         readCmd      <= 1'b0;
         case (state)
            sIdle: if (initDone) state <= sSendCmd0;
            sSendCmd0: begin
               sdCmd      <= issue('0, 8'd0, 8'h00);   // no response
               cmdWaitCnt <= '0;
               state      <= sCmd0Wait;
            end
            sCmd0Wait: begin
               cmdWaitCnt <= cmdWaitCnt + 1'b1;
               if (cmdWaitCnt >= cmd0WaitCycles) state <= sSendCmd8;
            end
            sSendCmd8: begin
               sdCmd <= issue(cmd8Arg, 8'd8, respFlagsR1);
               state <= sCmd8Wait;
            end
            sCmd8Wait: if (dataReady) state <= sSendCmd55;
            sSendCmd55: begin
               sdCmd <= issue({rca, cmd55StuffBits}, 8'd55, respFlagsR1);
               state <= sCmd55Wait;
            end
            sCmd55Wait: begin
               // one CMD55 state serves both app commands
               if (dataReady) begin
                  if (!acmd41Done)     state <= sSendAcmd41;
                  else if (!acmd6Done) state <= sSendAcmd6;
                  else                 state <= sSendCmd16;
               end
            end
            sSendAcmd41: begin
               sdCmd <= issue(acmd41Arg, 8'd41, respFlagsR3);
               state <= sAcmd41Wait;
            end
            sAcmd41Wait: begin
               if (dataReady) begin
                  acmd41Done <= cmdResponse[ocrReadyBit];
                  state      <= sAcmd41Check;
               end
            end
            sAcmd41Check: state <= acmd41Done ? sSendCmd2 : sSendCmd55;   // retry while busy
            sSendCmd2: begin
               sdCmd <= issue('0, 8'd2, respFlagsR2);
               state <= sCmd2Wait;
            end
            sCmd2Wait: if (dataReady) state <= sSendCmd3;
            sSendCmd3: begin
               sdCmd <= issue('0, 8'd3, respFlagsR1);
               state <= sCmd3Wait;
            end
            sCmd3Wait: begin
               if (dataReady) begin
                  rca   <= cmdResponse[rcaMsb -: 16];   // published RCA
                  state <= sSendCmd7;
               end
            end
            sSendCmd7: begin
               sdCmd <= issue({rca, 16'h0000}, 8'd7, respFlagsR1);
               state <= sCmd7Wait;
            end
            sCmd7Wait: if (dataReady) state <= sSendCmd55;
            sSendAcmd6: begin
               sdCmd <= issue(acmd6Arg, 8'd6, respFlagsR1);
               state <= sAcmd6Wait;
            end
            sAcmd6Wait: begin
               if (dataReady) begin
                  acmd6Done <= 1'b1;
                  state     <= sSendCmd16;
               end
            end
            sSendCmd16: begin
               sdCmd <= issue(blockLenArg, 8'd16, respFlagsR1);
               state <= sCmd16Wait;
            end
            sCmd16Wait: begin
               if (dataReady) begin
                  sdReady <= 1'b1;   // held until reset
                  state   <= sReady;
               end
            end

            // block transfers
            sReady: begin
               if (reqValid) begin
                  curReq       <= xferReq;
                  xferDone.tag <= xferReq.tag;
                  state        <= sXferCheck;
               end
            end
            sXferCheck: begin
               if (curReq.isWrite ? !writeFifoAlmostEmpty : !readFifoAlmostFull) begin
                  state <= sSendXfer;
               end
            end
            sSendXfer: begin
               sdCmd <= issue(curReq.address,
                              {2'b00, (curReq.isWrite ? opWrite : opRead)}, respFlagsR1);
               state <= sXferWait;
            end
            sXferWait: begin
               if (dataReady) begin
                  xferDone.respIndex <= cmdResponse[respIndexMsb -: 6];
                  writeCmd           <= curReq.isWrite;
                  readCmd            <= !curReq.isWrite;
                  state              <= sDataWait;
               end
            end
            sDataWait: begin
               if (curReq.isWrite ? writeDone : readDone) begin
                  xferDone.dataStatus <= dataStatus;
                  doneValid           <= 1'b1;
                  state               <= sResult;
               end
            end
            sResult: begin
               if (resultSpace) begin   // hand-off this edge
                  doneValid <= 1'b0;
                  state     <= sReady;
               end
            end
            default: state <= sIdle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////
   dataStrobeExcl: assert property (@(posedge sdClkIn) disable iff (initRst)
      !(writeCmd && readCmd))
      else $error("write and read started together");

   newCmdPulse: assert property (@(posedge sdClkIn) disable iff (initRst)
      sdCmd.newCmd |=> !sdCmd.newCmd)
      else $error("newCmd held for two cycles");

endmodule

// File: logic/sdCmdFetch.sv
// decode stage of the SD engine
//    command FIFO read with two cycle latency
//    opcode filter and one entry request holding register

`timescale 1ns/100ps

module sdCmdFetch import sdEnginePkg::*; (
   input  logic    sdClkIn,
   input  logic    initRst,
   input  logic    sdReady,
   input  cmdWordT cmdFifoData,
   input  logic    cmdFifoEmpty,
   input  logic    reqTaken,
   output logic    cmdFifoRdEn,
   output xferReqT xferReq,
   output logic    reqValid
);

   logic [1:0] fetchCnt;    // 0 idle, 1 read issued, 2 word on bus
   opcodeT     opcode;
   logic       holdFree;
   logic       capture;
   logic       supported;

   assign opcode    = cmdFifoData[63:58];
   assign supported = (opcode == opWrite) || (opcode == opRead);
   assign holdFree  = !reqValid || reqTaken;   // empty, or leaving this cycle
   assign capture   = (fetchCnt == 2'd2);

   // fetch sequencing
   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         fetchCnt    <= 2'd0;
         cmdFifoRdEn <= 1'b0;
      end else begin
         cmdFifoRdEn <= 1'b0;
         if (fetchCnt == 2'd0) begin
            if (sdReady && !cmdFifoEmpty && holdFree) begin
               cmdFifoRdEn <= 1'b1;
               fetchCnt    <= 2'd1;
            end
         end else if (capture) begin
            fetchCnt <= 2'd0;
         end else begin
            fetchCnt <= fetchCnt + 2'd1;   // waiting out FIFO latency
         end
      end
   end

   // holding register, unsupported opcodes never set it
   always_ff @(posedge sdClkIn or posedge initRst) begin
      if (initRst) begin
         reqValid <= 1'b0;
      end else if (capture && supported) begin
         reqValid <= 1'b1;
      end else if (reqTaken) begin
         reqValid <= 1'b0;
      end
   end

   always_ff @(posedge sdClkIn) begin
      if (capture && supported) begin
         xferReq.isWrite <= (opcode == opWrite);
         xferReq.tag     <= cmdFifoData[57:50];
         xferReq.address <= cmdFifoData[31:0];
      end
   end

   // a read is only started on a non-empty FIFO, the flag must still agree
   rdEnNotEmpty: assert property (@(posedge sdClkIn) disable iff (initRst)
      cmdFifoRdEn |-> !cmdFifoEmpty)
      else $error("command FIFO read while empty");

endmodule

// File: logic/sdEnginePkg.sv
// SD card command engine shared definitions
//    width types for FIFO words, card commands and responses
//    argument and setting constants of the bring-up sequence
//    sequencer state encoding
//    request, completion and PHY command structs

package sdEnginePkg;

   ////////////////////////////////////////////////////////////
   // width types
   ////////////////////////////////////////////////////////////
   typedef logic [71:0] cmdWordT;      // opcode 63:58, tag 57:50, address 31:0
   typedef logic [35:0] resultWordT;   // status 18:15, index 13:8, tag 7:0
   typedef logic [31:0] sdArgT;
   typedef logic [15:0] cmdSettingT;   // cmd index in upper byte, resp flags lower
   typedef logic [47:0] shortRespT;
   typedef logic [15:0] rcaT;
   typedef logic [5:0]  opcodeT;
   typedef logic [7:0]  tagT;
   typedef logic [3:0]  dataStatT;

   ////////////////////////////////////////////////////////////
   // constants
   ////////////////////////////////////////////////////////////
   localparam opcodeT opWrite = 6'd24;   // single block write
   localparam opcodeT opRead  = 6'd17;   // single block read

   // response type flags as the command PHY decodes them
   localparam logic [7:0] respFlagsR1 = 8'h1A;
   localparam logic [7:0] respFlagsR3 = 8'h12;   // no crc / index check
   localparam logic [7:0] respFlagsR2 = 8'h09;

   localparam sdArgT cmd8Arg     = 32'h0000_01AA;   // 2.7-3.6V, check pattern AA
   localparam sdArgT acmd41Arg   = 32'h40FF_8000;   // HCS plus voltage window
   localparam sdArgT acmd6Arg    = 32'h0000_0002;   // 4-bit bus
   localparam sdArgT blockLenArg = 32'd512;

   localparam logic [15:0] cmd55StuffBits = 16'hAAAA;

   localparam int cmd0WaitCycles = 256;   // idle time after go-idle
   localparam int ocrReadyBit    = 39;    // busy bit of OCR in R3
   localparam int rcaMsb         = 39;    // RCA sits in 39:24 of R6
   localparam int respIndexMsb   = 45;

   ////////////////////////////////////////////////////////////
   // sequencer states
   ////////////////////////////////////////////////////////////
   typedef enum logic [4:0] {
      sIdle, sSendCmd0, sCmd0Wait, sSendCmd8, sCmd8Wait,
      sSendCmd55, sCmd55Wait, sSendAcmd41, sAcmd41Wait, sAcmd41Check,
      sSendCmd2, sCmd2Wait, sSendCmd3, sCmd3Wait, sSendCmd7, sCmd7Wait,
      sSendAcmd6, sAcmd6Wait, sSendCmd16, sCmd16Wait,
      sReady, sXferCheck, sSendXfer, sXferWait, sDataWait, sResult
   } seqStateT;

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic       newCmd;     // one cycle strobe
      sdArgT      argument;
      cmdSettingT setting;
   } sdCmdReqT;

   typedef struct packed {
      logic  isWrite;
      tagT   tag;
      sdArgT address;
   } xferReqT;

   typedef struct packed {
      tagT        tag;
      logic [5:0] respIndex;
      dataStatT   dataStatus;
   } xferDoneT;

endpackage
